// File: tb.f
rtl/mem_pkg.sv
rtl/mem_if.sv
rtl/mem_core.sv
rtl/mem_bank.sv
rtl/apb_mem_ctrl.sv
rtl/apb_mem_top.sv
testbench/tb_clk_gen.sv
testbench/tb_apb_mem.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the APB SRAM testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_apb_mem \
  -f tb.f \
  -Mdir obj_dir -o sim_apb_mem

output="$(./obj_dir/sim_apb_mem)"
echo "$output"

if grep -qx "PASS: all tests" <<< "$output"; then
  exit 0
else
  echo "Simulation reported failure"
  exit 1
fi

// File: testbench/tb_apb_mem.sv
/*
 * APB SRAM testbench with driver tasks, shadow memory,
 * concurrent checks and error counts
 */

`timescale 1ns/100ps
`default_nettype none

module tb_apb_mem;

  import mem_pkg::*;

  localparam int TIMEOUT_CYCLES = 20;

  logic      clk, rst_n;
  logic      psel, penable, pwrite;
  apb_addr_t paddr;
  data_t     pwdata, prdata;
  strb_t     pstrb;
  logic      pready, pslverr;

  // Per-cycle expectations set on the falling edge
  logic  chk_reset;   // Quiet outputs after reset
  logic  exp_wait;    // First access cycle of a good read
  logic  exp_done;    // Cycle that must complete the transfer
  logic  exp_rd;      // prdata_o must match exp_rdata
  logic  exp_err;
  data_t exp_rdata;
  logic  ready_q;     // pready_o as seen at the last rising edge

  int    assert_errors = 0;
  int    timeout_count = 0;
  int    seed = 80;
  data_t shadow [256];  // One entry per bank word

  tb_clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  apb_mem_top u_apb_mem_top (
    .clk_i(clk), .rst_n_i(rst_n), .psel_i(psel), .penable_i(penable),
    .pwrite_i(pwrite), .paddr_i(paddr), .pwdata_i(pwdata), .pstrb_i(pstrb),
    .pready_o(pready), .pslverr_o(pslverr), .prdata_o(prdata)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) ready_q <= 1'b0;
    else        ready_q <= pready;
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Wrong value on a DUT output
  task automatic report_mismatch(input string name, input data_t exp_v, input data_t act_v);
    $display("[ERROR] %s expected %h got %h", name, exp_v, act_v);
    assert_errors++;
  endtask

  a_rst_ready: assert property (@(posedge clk) disable iff (!rst_n) chk_reset |-> !pready)
    else report_mismatch("pready_o", 32'h0, $sampled(pready));
  a_rst_err: assert property (@(posedge clk) disable iff (!rst_n) chk_reset |-> !pslverr)
    else report_mismatch("pslverr_o", 32'h0, $sampled(pslverr));
  a_rst_rdata: assert property (@(posedge clk) disable iff (!rst_n)
                                chk_reset |-> prdata == '0)
    else report_mismatch("prdata_o", 32'h0, $sampled(prdata));
  a_wait: assert property (@(posedge clk) disable iff (!rst_n) exp_wait |-> !pready)
    else report_mismatch("pready_o", 32'h0, $sampled(pready));
  a_done: assert property (@(posedge clk) disable iff (!rst_n) exp_done |-> pready)
    else report_mismatch("pready_o", 32'h1, $sampled(pready));
  a_slverr: assert property (@(posedge clk) disable iff (!rst_n)
                             exp_done |-> pslverr == exp_err)
    else report_mismatch("pslverr_o", exp_err, $sampled(pslverr));
  a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
                            exp_rd |-> prdata == exp_rdata)
    else report_mismatch("prdata_o", exp_rdata, $sampled(prdata));
  // Error only alongside the response
  a_err_ready: assert property (@(posedge clk) disable iff (!rst_n) pslverr |-> pready)
    else report_mismatch("pready_o", 32'h1, $sampled(pready));

  ////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////

  // Misaligned or beyond 1 KiB
  function automatic logic addr_error(input apb_addr_t addr);
    return (|addr[1:0]) | (|addr[11:10]);
  endfunction

  function automatic data_t merge_lanes(input data_t old_w, input data_t new_w,
                                        input strb_t strb);
    data_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];  // Only strobed lanes
    end
    return res;
  endfunction

  // Expected handshake for access cycle n of one transfer
  task set_access_flags(input int n, input logic wr, input logic err, input data_t rd_exp);
    logic good_read;
    good_read = !wr && !err;
    exp_wait  = good_read && (n == 1);
    exp_done  = good_read ? (n == 2) : (n == 1);
    exp_rd    = good_read && (n == 2);
    exp_err   = err;
    exp_rdata = rd_exp;
  endtask

  ////////////////////////////////////////
  // APB driver
  ////////////////////////////////////////

  task apb_transfer(input logic wr, input apb_addr_t addr, input data_t data,
                    input strb_t strb, input logic err, input data_t rd_exp);
    int   cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    @(negedge clk);
    psel    = 1'b1;  // Setup phase
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    pstrb   = strb;
    @(negedge clk);
    penable = 1'b1;
    set_access_flags(1, wr, err, rd_exp);
    while (!done && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
      if (ready_q) done = 1'b1;
      else         set_access_flags(cycles + 1, wr, err, rd_exp);
    end
    set_access_flags(0, wr, err, rd_exp);  // Nothing expected between transfers
    psel    = 1'b0;
    penable = 1'b0;
    if (!done) begin
      $display("Timeout: no pready_o within %0d cycles at address %h", TIMEOUT_CYCLES, addr);
      timeout_count++;
    end
  endtask

  task apb_write(input apb_addr_t addr, input data_t data, input strb_t strb);
    logic err;
    err = addr_error(addr);
    apb_transfer(1'b1, addr, data, strb, err, '0);
    if (!err) shadow[addr[9:2]] = merge_lanes(shadow[addr[9:2]], data, strb);
  endtask

  task apb_read(input apb_addr_t addr);
    logic err;
    err = addr_error(addr);
    apb_transfer(1'b0, addr, '0, '0, err, err ? '0 : shadow[addr[9:2]]);
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    int          waited;
    logic [31:0] rnd;
    logic [7:0]  idx;
    addr_t       a;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    pstrb     = '0;
    chk_reset = 1'b0;
    set_access_flags(0, 1'b1, 1'b0, '0);  // No transfer expectations yet
    waited = 0;
    while (!rst_n && waited < TIMEOUT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (!rst_n) begin
      $display("Timeout: reset was never released");
      timeout_count++;
    end
    chk_reset = 1'b1;  // Quiet bus right after reset
    repeat (3) @(negedge clk);
    chk_reset = 1'b0;
    for (int i = 0; i < 256; i++) begin
      a = addr_t'(i * 4);
      apb_write({2'b00, a}, {6'h2b, a, 6'h15, ~a}, 4'hf);  // Fill from full address
    end
    for (int i = 0; i < 40; i++) begin  // Full word round trips
      rnd = $random(seed);
      idx = rnd[7:0];
      rnd = $random(seed);
      apb_write({2'b00, idx, 2'b00}, rnd, 4'hf);
      apb_read({2'b00, idx, 2'b00});
    end
    for (int i = 0; i < 20; i++) begin  // Byte lanes
      rnd = $random(seed);
      idx = rnd[7:0];
      rnd = $random(seed);
      apb_write({2'b00, idx, 2'b00}, rnd, rnd[11:8]);
      apb_read({2'b00, idx, 2'b00});
    end
    for (int off = 1; off < 4; off++) begin  // Misaligned
      rnd = $random(seed);
      idx = rnd[7:0];
      apb_write({2'b00, idx, off[1:0]}, ~rnd, 4'hf);
      apb_read({2'b00, idx, off[1:0]});
      apb_read({2'b00, idx, 2'b00});
    end
    for (int hi = 1; hi < 4; hi++) begin  // Beyond 1 KiB must not alias
      rnd = $random(seed);
      idx = rnd[7:0];
      apb_write({hi[1:0], idx, 2'b00}, rnd, 4'hf);
      apb_read({hi[1:0], idx, 2'b00});
      apb_read({2'b00, idx, 2'b00});
    end
    for (int i = 0; i < 256; i++) begin
      apb_read(apb_addr_t'(i * 4));  // Final sweep against the shadow
    end
    repeat (2) @(negedge clk);
    $display("Errors: %0d assertion, %0d timeout", assert_errors, timeout_count);
    if (assert_errors == 0 && timeout_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/tb_clk_gen.sv
/*
 * Testbench clock and reset source
 */

`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 40,  // Clock period
  parameter int RESET_CYCLES = 5    // Rising edges held in reset
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Sync reset, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: rtl/apb_mem_top.sv
/*
 * APB SRAM top level
 * Controller and bank joined through mem_if
 */

`timescale 1ns/100ps
`default_nettype none

module apb_mem_top (
  input  logic               clk_i,
  input  logic               rst_n_i,     // Sync, active low
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  mem_pkg::apb_addr_t paddr_i,     // Byte address
  input  mem_pkg::data_t     pwdata_i,
  input  mem_pkg::strb_t     pstrb_i,     // Byte lane strobes
  output logic               pready_o,
  output logic               pslverr_o,   // Misaligned or out of range
  output mem_pkg::data_t     prdata_o
);

  ////////////////////////////////////////
  // Internal bus
  ////////////////////////////////////////

  mem_if u_mem_if ();

  ////////////////////////////////////////
  // APB slave
  ////////////////////////////////////////

  apb_mem_ctrl u_ctrl (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .psel_i   (psel_i),
    .penable_i(penable_i),
    .pwrite_i (pwrite_i),
    .paddr_i  (paddr_i),
    .pwdata_i (pwdata_i),
    .pstrb_i  (pstrb_i),
    .pready_o (pready_o),
    .pslverr_o(pslverr_o),
    .prdata_o (prdata_o),
    .mem_o    (u_mem_if.ctrl)
  );

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  // Default 1 KiB, 32-bit words
  mem_bank #(
    .ADDR_WIDTH(mem_pkg::ADDR_WIDTH),
    .DATA_SIZE (mem_pkg::DATA_SIZE)
  ) u_bank (
    .clk_i(clk_i),
    .bus_i(u_mem_if.bank)
  );

endmodule

`default_nettype wire

// File: rtl/apb_mem_ctrl.sv
/*
 * APB slave controller for the SRAM bank
 * Alignment and range checks, one wait state on reads
 */

`timescale 1ns/100ps
`default_nettype none

module apb_mem_ctrl (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  mem_pkg::apb_addr_t paddr_i,
  input  mem_pkg::data_t    pwdata_i,
  input  mem_pkg::strb_t    pstrb_i,
  output logic              pready_o,
  output logic              pslverr_o,
  output mem_pkg::data_t    prdata_o,
  mem_if.ctrl               mem_o
);

  import mem_pkg::*;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        setup_phase;  // psel without penable
  logic        apb_access;   // psel and penable
  logic        misaligned;
  logic        out_of_range;
  logic        addr_err;
  logic        good_write;
  logic        read_capture;
  data_t       prdata_q;

  assign setup_phase = psel_i & ~penable_i;
  assign apb_access  = psel_i & penable_i;

  assign misaligned   = |paddr_i[DATA_SIZE-1:0];                // Not word aligned
  assign out_of_range = |paddr_i[APB_ADDR_WIDTH-1:ADDR_WIDTH];  // Beyond 1 KiB
  assign addr_err     = misaligned | out_of_range;

  // Writes complete in the first access cycle
  assign good_write = (state_q == ST_IDLE) & apb_access & pwrite_i & ~addr_err;

  // Read data sampled at the end of the first access cycle
  assign read_capture = (state_q == ST_READ_WAIT) & apb_access;

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        // Good reads get their wait state
        if (setup_phase && !pwrite_i && !addr_err) begin
          state_d = ST_READ_WAIT;
        end
      end
      ST_READ_WAIT: begin
        if (apb_access) begin
          state_d = ST_RESP;
        end
      end
      ST_RESP: begin
        state_d = ST_IDLE;  // Response lasts one cycle
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////
  // Read data register
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      prdata_q <= '0;
    end else if (read_capture) begin
      prdata_q <= mem_o.rdata;  // Held until the next read
    end
  end

  assign prdata_o = prdata_q;

  ////////////////////////////////////////
  // APB response
  ////////////////////////////////////////

  // Writes and errors answer at once, reads from ST_RESP
  assign pready_o = ((state_q == ST_IDLE) & apb_access & (pwrite_i | addr_err))
                  | (state_q == ST_RESP);

  assign pslverr_o = (state_q == ST_IDLE) & apb_access & addr_err;

  ////////////////////////////////////////
  // Bank request
  ////////////////////////////////////////

  assign mem_o.cs    = good_write | read_capture;      // Never on error
  assign mem_o.addr  = addr_t'(paddr_i[ADDR_WIDTH-1:0]);
  assign mem_o.wdata = pwdata_i;
  assign mem_o.wstrb = pwrite_i ? pstrb_i : '0;        // No lanes on reads

endmodule

`default_nettype wire

// File: rtl/mem_bank.sv
/*
 * Word wide memory bank built from byte columns
 * Aligned requests only
 */

`timescale 1ns/100ps
`default_nettype none

module mem_bank #(
  parameter int ADDR_WIDTH = mem_pkg::ADDR_WIDTH,  // Byte address bits
  parameter int DATA_SIZE  = mem_pkg::DATA_SIZE    // log2 of bytes per word
) (
  input logic clk_i,
  mem_if.bank bus_i
);

  ////////////////////////////////////////
  // Lane write enables
  ////////////////////////////////////////

  logic [(2**DATA_SIZE)-1:0]     col_we;   // Per column write
  logic [(8*(2**DATA_SIZE))-1:0] word_rd;  // Assembled read word

  // Strobe only counts while selected
  assign col_we = bus_i.wstrb & {(2**DATA_SIZE){bus_i.cs}};

  ////////////////////////////////////////
  // Byte columns
  ////////////////////////////////////////

  for (genvar i = 0; i < 2**DATA_SIZE; i++) begin : g_col
    mem_core #(
      .ELEM_WIDTH(8),
      .ADDR_WIDTH(ADDR_WIDTH - DATA_SIZE)  // Word index
    ) u_mem_core (
      .clk_i  (clk_i),
      .we_i   (col_we[i]),
      .addr_i (bus_i.addr[ADDR_WIDTH-1:DATA_SIZE]),  // Low bits dropped
      .wdata_i(bus_i.wdata[8*i +: 8]),
      .rdata_o(word_rd[8*i +: 8])                    // Lane i of the word
    );
  end

  // Read word back to the controller
  assign bus_i.rdata = word_rd;

endmodule

`default_nettype wire

// File: rtl/mem_core.sv
/*
 * Single storage column
 * Synchronous write, combinational read
 */

`timescale 1ns/100ps
`default_nettype none

module mem_core #(
  parameter int ELEM_WIDTH = 8,  // Bits per element
  parameter int ADDR_WIDTH = 8   // Element address bits
) (
  input  logic                  clk_i,
  input  logic                  we_i,     // Write enable
  input  logic [ADDR_WIDTH-1:0] addr_i,   // Element index
  input  logic [ELEM_WIDTH-1:0] wdata_i,
  output logic [ELEM_WIDTH-1:0] rdata_o
);

  // Plain RAM array
  logic [ELEM_WIDTH-1:0] mem [2**ADDR_WIDTH];

  ////////////////////////////////////////
  // Write port
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[addr_i] <= wdata_i;
    end
  end

  // Read port, no latency
  assign rdata_o = mem[addr_i];

endmodule

`default_nettype wire

// File: rtl/mem_if.sv
/*
 * Request and read data bus between APB controller and bank
 */

`timescale 1ns/100ps
`default_nettype none

interface mem_if;

  import mem_pkg::*;

  logic  cs;     // Chip select
  addr_t addr;   // Aligned byte address
  data_t wdata;  // Write word
  strb_t wstrb;  // Byte lane enables
  data_t rdata;  // Word at addr, combinational

  // Controller side
  modport ctrl (
    output cs,
    output addr,
    output wdata,
    output wstrb,
    input  rdata
  );

  // Memory side
  modport bank (
    input  cs,
    input  addr,
    input  wdata,
    input  wstrb,
    output rdata
  );

endinterface

`default_nettype wire

// File: rtl/mem_pkg.sv
/*
 * Shared widths, vector types and controller states
 * for the APB SRAM
 */

`default_nettype none

package mem_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int APB_ADDR_WIDTH = 12;  // APB byte address
  localparam int ADDR_WIDTH     = 10;  // Bank byte address, 1 KiB
  localparam int DATA_SIZE      = 2;   // log2 of bytes per word
  localparam int DATA_BYTES     = 2 ** DATA_SIZE;
  localparam int DATA_WIDTH     = 8 * DATA_BYTES;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef logic [APB_ADDR_WIDTH-1:0] apb_addr_t;
  typedef logic [ADDR_WIDTH-1:0]     addr_t;
  typedef logic [DATA_WIDTH-1:0]     data_t;
  typedef logic [DATA_BYTES-1:0]     strb_t;  // One bit per byte lane

  // Controller FSM
  typedef enum logic [1:0] {
    ST_IDLE,       // Setup phase, writes and errors
    ST_READ_WAIT,  // Read access, capture data
    ST_RESP        // Read data out
  } ctrl_state_e;

endpackage

`default_nettype wire
